// File: all.f
+incdir+verilog
verilog/stepper_pkg.sv
verilog/move_if.sv
verilog/spi_word_rx.sv
verilog/cmd_decoder.sv
verilog/step_generator.sv
verilog/hbridge_driver.sv
verilog/stepper_ctrl_top.sv
sim/tb_stepper.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_stepper -f all.f -o sim_stepper \
  > build.log 2>&1 && ./obj_dir/sim_stepper > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "Simulation passed" || {
  echo "Simulation failed, see build.log and sim.log"
  exit 1
}

// File: sim/tb_stepper.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

module tb_stepper
  import stepper_pkg::*;
();

  localparam real PI = 3.14159265358979;
  localparam word_t HALF_TURN = 64'h8000_0000_0000_0000;  // Carry every second tick

  // Watchdog budget from move lengths in cycles, about 80 SPI words and PWM windows
  localparam longint MOVE_CYCLES = 1000*4 + 600*4 + 600*10 + 9*2*4 + (32+32+10)*4;
  localparam longint SPI_CYCLES  = 80 * 660;
  localparam longint PWM_CYCLES  = 3 * 256;
  localparam longint WATCHDOG_NS = 2 * (MOVE_CYCLES + SPI_CYCLES + PWM_CYCLES) * 10;

  logic CLK;
  logic reset, sck, ssel, mosi;
  logic miso, led, busy, step, dir;
  logic phase_a1, phase_a2, phase_b1, phase_b2, pwm_a, pwm_b;

  integer seed = 15576;
  string  cur_test = "reset";
  word_t  prev_word = '0;  // Word the DUT should echo next
  word_t  echo_word;
  word_t  inc, inc_inc;
  int     checks = 0;
  int     errors = 0;
  int     prop_errors = 0;
  int     step_cnt = 0;
  int     busy_cnt = 0;
  int     last_steps = 0;
  int     pos_model = 0;
  int     ms_model = 0;
  int     div_model = `DIV_RESET;
  bit     en_model = 1'b0;
  bit     led_model = 1'b0;

  stepper_ctrl_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(negedge CLK) begin
    if (step) step_cnt++;
    if (busy) busy_cnt++;
  end

  // A step pulse always follows a tick inside a move
  assert property (@(posedge CLK) disable iff (reset) step |-> $past(busy))
    else begin
      prop_errors++;
      $display("[ERROR] step_in_move: expected busy 1 before step, actual 0");
    end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // Carry count of the phase accumulator seen as unsigned wrap
  function automatic int model_steps(input word_t dur, input word_t rate0, input word_t dd);
    word_t rate;
    word_t acc;
    word_t nxt;
    word_t t;
    int    n;
    rate = rate0;
    acc  = '0;
    n    = 0;
    for (t = '0; t < dur; t++) begin
      rate = rate + dd;
      nxt  = acc + rate;
      if (nxt < acc) n++;
      acc = nxt;
    end
    return n;
  endfunction

  function automatic int scaled_magnitude(input real x);
    if (x < 0.0) x = -x;
    return $rtoi(255.0 * x + 0.5);
  endfunction

  // One SPI frame at CLK/10 with the echo checked before each rising SCK
  task automatic send_word(input word_t w);
    int i;
    @(posedge CLK);
    ssel <= 1'b0;
    repeat (5) @(posedge CLK);
    for (i = 63; i >= 0; i--) begin
      mosi <= w[i];
      repeat (4) @(posedge CLK);
      @(negedge CLK);
      check({cur_test, " echo"}, 64'(prev_word[i]), 64'(miso));
      @(posedge CLK);
      sck <= 1'b1;
      repeat (5) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (5) @(posedge CLK);
    ssel <= 1'b1;
    repeat (5) @(posedge CLK);
    prev_word = w;
    led_model = ~led_model;  // Toggles on every received word
    check({cur_test, " led"}, 64'(led_model), 64'(led));
  endtask

  task automatic set_divisor(input int div);
    send_word({CMD_DIVISOR, 56'(div)});
    div_model = div;
  endtask

  task automatic set_microstep(input int ms);
    send_word({CMD_MICROSTEP, 56'(ms)});
    ms_model = (ms > `MAX_MICROSTEP) ? `MAX_MICROSTEP : ms;
  endtask

  task automatic send_move(input word_t dur, input word_t rate0, input word_t dd, input bit fwd);
    logic [7:0] hdr;
    hdr    = CMD_MOVE;
    hdr[0] = fwd;  // Header bit 0 is the direction
    send_word({hdr, 56'h0});
    send_word(dur);
    send_word(rate0);
    send_word(dd);
  endtask

  task automatic check_phases();
    logic sa;
    logic sb;
    logic [3:0] exp;
    sa  = (pos_model < 32);                      // Sine sign with half-step offset
    sb  = (pos_model < 16) || (pos_model >= 48); // Cosine sign
    exp = en_model ? {sa, !sa, sb, !sb} : 4'b0000;
    check({cur_test, " phases"}, 64'(exp), 64'({phase_a1, phase_a2, phase_b1, phase_b2}));
  endtask

  task automatic do_move(input word_t dur, input word_t rate0, input word_t dd, input bit extra,
                         input bit fwd);
    int exp_steps;
    int step_base;
    int busy_base;
    int waited;
    int delta;
    exp_steps = model_steps(dur, rate0, dd);
    step_base = step_cnt;
    busy_base = busy_cnt;
    send_move(dur, rate0, dd, fwd);
    waited = 0;
    while (busy_cnt == busy_base && waited < 20) begin
      @(negedge CLK);
      waited++;
    end
    if (busy_cnt == busy_base) begin
      errors++;
      $display("%s: the move never started, busy did not rise", cur_test);
    end
    if (extra) send_move(dur, rate0, dd, fwd);  // Arrives while busy and must be dropped
    while (busy) @(negedge CLK);
    repeat (3) @(negedge CLK);
    last_steps = step_cnt - step_base;
    check({cur_test, " steps"}, 64'(exp_steps), 64'(last_steps));
    check({cur_test, " busy cycles"}, dur * 64'(div_model + 1), 64'(busy_cnt - busy_base));
    check({cur_test, " dir"}, 64'(fwd), 64'(dir));
    if (exp_steps > 0) en_model = 1'b1;
    delta     = exp_steps * (16 >> ms_model) % 64;
    pos_model = fwd ? (pos_model + delta) % 64 : (pos_model + 64 - delta) % 64;
    check_phases();
  endtask

  task automatic check_pwm();
    int  ha;
    int  hb;
    real ang;
    ha = 0;
    hb = 0;
    repeat (256) begin
      @(negedge CLK);
      if (pwm_a) ha++;
      if (pwm_b) hb++;
    end
    ang = (real'(pos_model) + 0.5) * PI / 32.0;
    check({cur_test, " pwm_a duty"}, 64'(scaled_magnitude($sin(ang))), 64'(ha));
    check({cur_test, " pwm_b duty"}, 64'(scaled_magnitude($cos(ang))), 64'(hb));
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests were still running after %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    reset <= 1'b1;
    sck   <= 1'b0;
    ssel  <= 1'b1;
    mosi  <= 1'b0;
    repeat (2) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    check("reset", 64'h0, 64'({busy, step, miso, phase_a1, phase_a2, phase_b1, phase_b2,
                               pwm_a, pwm_b}));

    cur_test = "echo";
    repeat (6) begin
      echo_word     = {$random(seed), $random(seed)};
      echo_word[63] = 1'b1;  // Header above every opcode
      send_word(echo_word);
    end

    cur_test = "constant_rate";
    set_divisor(3);
    do_move(64'd1000, {$random(seed), $random(seed)}, '0, 1'b1, 1'b1);

    // Same move at two divisors
    cur_test = "accelerating";
    inc      = {$random(seed), $random(seed)};
    inc_inc  = {$random(seed), $random(seed)};
    set_divisor(3);
    do_move(64'd600, inc, inc_inc, 1'b0, 1'b1);
    set_divisor(9);
    do_move(64'd600, inc, inc_inc, 1'b0, 1'b1);

    cur_test = "full_step";
    set_microstep(0);
    set_divisor(3);
    repeat (5) do_move(64'd2, HALF_TURN, '0, 1'b0, 1'b1);

    cur_test = "full_step_reverse";
    repeat (4) do_move(64'd2, HALF_TURN, '0, 1'b0, 1'b0);

    cur_test = "microstep_4";
    set_microstep(4);
    do_move(64'd32, HALF_TURN, '0, 1'b0, 1'b1);  // 16 steps
    check_pwm();

    cur_test = "microstep_clamp";
    set_microstep(7);
    do_move(64'd32, HALF_TURN, '0, 1'b0, 1'b1);
    check_pwm();
    do_move(64'd10, HALF_TURN, '0, 1'b0, 1'b1);  // 5 steps to a position inside the table
    check_pwm();

    $display("Checks: %0d, check errors: %0d, property errors: %0d",
             checks, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verilog/stepper_ctrl_top.sv
`timescale 1ns/10ps

module stepper_ctrl_top
  import stepper_pkg::*;
(
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic led,
  output logic busy,
  output logic step,
  output logic dir,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b
);

  logic       word_valid;
  word_t      word;
  microstep_t microstep;

  move_if mv0 ();

  assign busy = mv0.busy;  // Status LED pin

  spi_word_rx rx0 (
    .CLK        (CLK),
    .reset      (reset),
    .sck        (sck),
    .ssel       (ssel),
    .mosi       (mosi),
    .miso       (miso),
    .word_valid (word_valid),
    .word       (word)
  );

  cmd_decoder dec0 (
    .CLK        (CLK),
    .reset      (reset),
    .word_valid (word_valid),
    .word       (word),
    .mv         (mv0.decoder),
    .microstep  (microstep),
    .led        (led)
  );

  step_generator gen0 (
    .CLK   (CLK),
    .reset (reset),
    .mv    (mv0.generator),
    .step  (step),
    .dir   (dir)
  );

  hbridge_driver hb0 (
    .CLK       (CLK),
    .reset     (reset),
    .step      (step),
    .dir       (dir),
    .microstep (microstep),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .pwm_a     (pwm_a),
    .pwm_b     (pwm_b)
  );

endmodule

// File: verilog/hbridge_driver.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

module hbridge_driver
  import stepper_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  logic       step,
  input  logic       dir,
  input  microstep_t microstep,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       pwm_a,
  output logic       pwm_b
);

  localparam int IDX_BITS = $clog2(`SINE_ENTRIES);
  // One full step is a quarter of the electrical cycle
  localparam logic [`POS_BITS-1:0] FULL_STEP = {2'b01, {(`POS_BITS-2){1'b0}}};

  logic [`POS_BITS-1:0] position;
  logic [`POS_BITS-1:0] delta;
  logic [IDX_BITS-1:0]  quad_idx;
  logic [`PWM_BITS-1:0] pwm_cnt;
  logic [`PWM_BITS-1:0] mag_a;
  logic [`PWM_BITS-1:0] mag_b;
  logic                 sign_a;
  logic                 sign_b;
  logic                 enabled;   // Set by the first step

  // 255 * sin((i + 0.5) * pi / 32), symmetric so mirroring is ~idx
  function automatic logic [`PWM_BITS-1:0] qsine(input logic [IDX_BITS-1:0] idx);
    case (idx)
      4'd0:    qsine = 8'd13;
      4'd1:    qsine = 8'd37;
      4'd2:    qsine = 8'd62;
      4'd3:    qsine = 8'd86;
      4'd4:    qsine = 8'd109;
      4'd5:    qsine = 8'd131;
      4'd6:    qsine = 8'd152;
      4'd7:    qsine = 8'd171;
      4'd8:    qsine = 8'd189;
      4'd9:    qsine = 8'd205;
      4'd10:   qsine = 8'd219;
      4'd11:   qsine = 8'd231;
      4'd12:   qsine = 8'd240;
      4'd13:   qsine = 8'd247;
      4'd14:   qsine = 8'd252;
      default: qsine = 8'd255;
    endcase
  endfunction

  assign delta    = FULL_STEP >> microstep;
  assign quad_idx = position[IDX_BITS-1:0];

  // Sine positive in the first half cycle, cosine in the first and last quarter
  assign sign_a = ~position[`POS_BITS-1];
  assign sign_b = ~(position[`POS_BITS-1] ^ position[`POS_BITS-2]);

  assign mag_a = position[`POS_BITS-2] ? qsine(~quad_idx) : qsine(quad_idx);
  assign mag_b = position[`POS_BITS-2] ? qsine(quad_idx) : qsine(~quad_idx);

  assign phase_a1 = enabled & sign_a;
  assign phase_a2 = enabled & ~sign_a;
  assign phase_b1 = enabled & sign_b;
  assign phase_b2 = enabled & ~sign_b;
  assign pwm_a    = enabled & (pwm_cnt < mag_a);
  assign pwm_b    = enabled & (pwm_cnt < mag_b);

  always_ff @(posedge CLK) begin
    if (reset) begin
      position <= '0;
      pwm_cnt  <= '0;
      enabled  <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      if (step) begin
        enabled  <= 1'b1;
        position <= dir ? position + delta : position - delta;  // Wraps at 64
      end
    end
  end

endmodule

// File: verilog/step_generator.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

module step_generator
  import stepper_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  move_if.generator  mv,
  output logic       step,
  output logic       dir
);

  logic [`DIV_BITS-1:0] div_cnt;
  word_t                ticks_left;
  rate_t                rate;
  rate_t                rate_inc;    // Held for the whole move
  rate_t                rate_next;
  word_t                accum;
  logic [`WORD_BITS:0]  sum;         // Carry in the top bit
  logic                 accept;
  logic                 tick;

  // Zero-length moves are not started
  assign accept = mv.start && !mv.busy && (mv.duration != '0);

  // Compare with >= so a lowered divisor still ends the current tick
  assign tick = mv.busy && (div_cnt >= mv.divisor);

  assign rate_next = rate + rate_inc;
  assign sum       = {1'b0, accum} + {1'b0, rate_next};

  // Rate and accumulator
  always_ff @(posedge CLK) begin
    if (accept) begin
      rate     <= mv.increment;
      rate_inc <= mv.increment_inc;
      accum    <= '0;
    end else if (tick) begin
      rate  <= rate_next;
      accum <= sum[`WORD_BITS-1:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      mv.busy    <= 1'b0;
      step       <= 1'b0;
      dir        <= 1'b0;
      div_cnt    <= '0;
      ticks_left <= '0;
    end else begin
      step <= 1'b0;
      if (accept) begin
        mv.busy    <= 1'b1;
        dir        <= mv.dir;  // Fixed for the move
        div_cnt    <= '0;
        ticks_left <= mv.duration;
      end else if (tick) begin
        div_cnt    <= '0;
        step       <= sum[`WORD_BITS];  // Carry out of bit 63
        ticks_left <= ticks_left - 1'b1;
        if (ticks_left == word_t'(1)) begin
          mv.busy <= 1'b0;
        end
      end else if (mv.busy) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// File: verilog/cmd_decoder.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

module cmd_decoder
  import stepper_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  logic       word_valid,
  input  word_t      word,
  move_if.decoder    mv,
  output microstep_t microstep,
  output logic       led
);

  localparam int PAYLOAD_BITS = `WORD_BITS - 8;

  typedef enum logic {
    ST_IDLE,
    ST_COLLECT
  } state_e;

  state_e     state;
  logic [1:0] data_cnt;   // Data words seen after a move header
  cmd_e       header;
  microstep_t ms_clamped;

  assign header = cmd_e'(word[`WORD_BITS-1 -: 8]);

  // Anything above the limit saturates
  assign ms_clamped = (word[PAYLOAD_BITS-1:0] > PAYLOAD_BITS'(`MAX_MICROSTEP)) ?
                      microstep_t'(`MAX_MICROSTEP) : word[$bits(microstep_t)-1:0];

  // Move words read by the generator only on start
  always_ff @(posedge CLK) begin
    if (word_valid && state == ST_COLLECT) begin
      case (data_cnt)
        2'd0:    mv.duration <= word;
        2'd1:    mv.increment <= $signed(word);
        default: mv.increment_inc <= $signed(word);
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= ST_IDLE;
      data_cnt   <= '0;
      mv.start   <= 1'b0;
      mv.dir     <= 1'b0;
      mv.divisor <= `DIV_BITS'(`DIV_RESET);
      microstep  <= '0;
      led        <= 1'b0;
    end else begin
      mv.start <= 1'b0;
      if (word_valid) begin
        led <= ~led;  // Activity blink
        case (state)
          ST_IDLE: begin
            data_cnt <= '0;
            if ({header[7:1], 1'b1} == CMD_MOVE) begin  // 0x01 forward, 0x00 reverse
              mv.dir <= header[0];
              state  <= ST_COLLECT;
            end else begin
              case (header)
                CMD_DIVISOR:   mv.divisor <= word[`DIV_BITS-1:0];
                CMD_MICROSTEP: microstep <= ms_clamped;
                default: ;  // Unknown opcode is ignored
              endcase
            end
          end
          ST_COLLECT: begin
            data_cnt <= data_cnt + 1'b1;
            if (data_cnt == 2'd2) begin
              mv.start <= 1'b1;  // Last word captured this cycle
              state    <= ST_IDLE;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

// File: verilog/spi_word_rx.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

module spi_word_rx
  import stepper_pkg::*;
(
  input  logic  CLK,
  input  logic  reset,
  input  logic  sck,
  input  logic  ssel,
  input  logic  mosi,
  output logic  miso,
  output logic  word_valid,
  output word_t word
);

  localparam int CNT_BITS = $clog2(`WORD_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`WORD_BITS - 1);

  logic [2:0]          sck_sr;    // Two sync flops plus edge history
  logic [2:0]          ssel_sr;
  logic [1:0]          mosi_sr;
  logic [CNT_BITS-1:0] bit_cnt;
  word_t               rx_shift;
  word_t               tx_shift;  // Echo of the last completed word
  logic                sck_rise;
  logic                sck_fall;
  logic                ssel_fall;
  logic                active;

  assign sck_rise  = sck_sr[1] & ~sck_sr[2];
  assign sck_fall  = ~sck_sr[1] & sck_sr[2];
  assign ssel_fall = ~ssel_sr[1] & ssel_sr[2];
  assign active    = ~ssel_sr[1];
  assign miso      = tx_shift[`WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sr  <= '0;
      ssel_sr <= '1;  // Idle deselected
      mosi_sr <= '0;
    end else begin
      sck_sr  <= {sck_sr[1:0], sck};
      ssel_sr <= {ssel_sr[1:0], ssel};
      mosi_sr <= {mosi_sr[0], mosi};
    end
  end

  // Receive side
  always_ff @(posedge CLK) begin
    if (active && sck_rise) begin
      rx_shift <= {rx_shift[`WORD_BITS-2:0], mosi_sr[1]};
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
      word       <= '0;
      tx_shift   <= '0;
    end else begin
      word_valid <= 1'b0;
      if (!active) begin
        bit_cnt <= '0;  // Partial word is dropped
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == LAST_BIT) begin
          word       <= {rx_shift[`WORD_BITS-2:0], mosi_sr[1]};
          word_valid <= 1'b1;
        end
      end

      // Echo reloads at frame start, MSB is on miso before the first rising edge
      if (ssel_fall) begin
        tx_shift <= word;
      end else if (active && sck_fall) begin
        tx_shift <= {tx_shift[`WORD_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

// File: verilog/move_if.sv
`timescale 1ns/10ps
`include "stepper_macros.svh"

// Move parameters from the decoder to the step generator
interface move_if
  import stepper_pkg::*;
();

  logic                 start;          // One-cycle pulse
  logic                 dir;
  word_t                duration;       // In ticks
  rate_t                increment;
  rate_t                increment_inc;
  logic [`DIV_BITS-1:0] divisor;        // Level, used at the next tick
  logic                 busy;

  modport decoder (
    output start,
    output dir,
    output duration,
    output increment,
    output increment_inc,
    output divisor
  );

  modport generator (
    input  start,
    input  dir,
    input  duration,
    input  increment,
    input  increment_inc,
    input  divisor,
    output busy
  );

endinterface

// File: verilog/stepper_pkg.sv
`include "stepper_macros.svh"

package stepper_pkg;

  // One SPI word as received from the host
  typedef logic [`WORD_BITS-1:0] word_t;

  // Rates are two's complement
  typedef logic signed [`WORD_BITS-1:0] rate_t;

  // Exponent 0..MAX_MICROSTEP
  typedef logic [$clog2(`MAX_MICROSTEP+1)-1:0] microstep_t;

  // Message header opcodes, top byte of the first word
  typedef enum logic [7:0] {
    CMD_MOVE      = 8'h01,  // Three data words follow
    CMD_DIVISOR   = 8'h03,  // Tick divisor in low bits
    CMD_MICROSTEP = 8'h04   // Exponent in low bits
  } cmd_e;

endpackage

// File: verilog/stepper_macros.svh
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// SPI word, phase accumulator and rate width
`define WORD_BITS 64

`define DIV_BITS 24       // Clock divisor
`define DIV_RESET 31      // Divisor after reset

// H-bridge drive
`define PWM_BITS 8        // PWM counter and coil amplitude
`define POS_BITS 6        // 64 positions per electrical cycle
`define MAX_MICROSTEP 4   // Highest microstep exponent

// Quarter-wave sine table depth
`define SINE_ENTRIES 16

`endif
